/* cnn_settings.svh */
`ifndef CNN_SETTINGS_SVH
`define CNN_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// frame geometry
//////////////////////////////////////////////////////////////////////

// small frame for simulation
`define SCREEN_W 8
`define SCREEN_H 8
`define COORD_BITS 3

// kernel edge and number of trees
`define KSIZE 3
`define NUM_KERNELS 2

// data widths
`define PIX_BITS 8
`define WEIGHT_BITS 4
`define SUM_BITS 16

// products, row sums, rectify
`define TREE_LATENCY 3

// valid convolution area only, no padding
`define FM_W (`SCREEN_W - 2)
`define FM_H (`SCREEN_H - 2)
`define FM_DEPTH (`FM_W * `FM_H)

// nine signed taps, tap 0 in the low nibble
// blur-like, sum of taps is 16
`define KERNEL_0_WEIGHTS 36'h121242121
// laplacian-like edge kernel, sum of taps is -1
`define KERNEL_1_WEIGHTS 36'hFFFF7FFFF

`endif

/* cnn_pkg.sv */
`default_nettype none

`include "cnn_settings.svh"

package cnn_pkg;

  //////////////////////////////////////////////////////////////////////
  // pixel stream
  //////////////////////////////////////////////////////////////////////

  // camera pixel, unsigned
  typedef logic [`PIX_BITS-1:0] pixel_t;

  // screen or feature map position
  typedef struct packed {
    logic [`COORD_BITS-1:0] x;
    logic [`COORD_BITS-1:0] y;
  } coord_t;

  // one incoming pixel, qualified by pix_valid
  typedef struct packed {
    coord_t pos;
    pixel_t data;
  } pix_in_t;

  // 3x3 neighbourhood, row-major, element 0 is the oldest pixel
  typedef pixel_t [`KSIZE*`KSIZE-1:0] window_t;

  //////////////////////////////////////////////////////////////////////
  // feature map
  //////////////////////////////////////////////////////////////////////

  // one rectified lane per kernel
  typedef pixel_t [`NUM_KERNELS-1:0] fm_word_t;

  typedef struct packed {
    coord_t   pos;
    fm_word_t value;
  } fm_wr_t;

  // host read request, kernel selects the lane
  typedef struct packed {
    logic   kernel;
    coord_t pos;
  } fm_rd_req_t;

endpackage

`default_nettype wire

/* window_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cnn_settings.svh"

// decides which pixel positions close a full 3x3 window
module window_ctrl (
  input  logic              clock,
  input  logic              rst_n,
  input  logic              pix_valid,
  input  cnn_pkg::pix_in_t  pix_in,
  output logic              win_valid,
  output cnn_pkg::coord_t   win_pos
);

  // window needs two earlier rows and two earlier columns
  localparam logic [`COORD_BITS-1:0] EDGE = `KSIZE - 1;

  logic full_window;

  // newest pixel is the bottom-right corner
  assign full_window = (pix_in.pos.x >= EDGE) && (pix_in.pos.y >= EDGE);

  // valid flag, one cycle per strobe
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      win_valid <= 1'b0;
    end else begin
      // idle cycles and edge pixels give no window
      win_valid <= pix_valid && full_window;
    end
  end

  // top-left corner of the window, same cycle as the buffer shift
  always_ff @(posedge clock) begin
    if (pix_valid) begin
      win_pos.x <= pix_in.pos.x - EDGE;
      win_pos.y <= pix_in.pos.y - EDGE;
    end
  end

  // only meaningful when win_valid is high
  // the feature map address is built from this corner

endmodule

`default_nettype wire

/* window_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cnn_settings.svh"

// line buffer that shows the 3x3 window ending at the newest pixel
module window_buffer (
  input  logic              clock,
  input  logic              rst_n,
  input  logic              pix_valid,
  input  cnn_pkg::pixel_t   pixel,
  output cnn_pkg::window_t  window
);

  //////////////////////////////////////////////////////////////////////
  // shift register
  //////////////////////////////////////////////////////////////////////

  // two full rows plus one kernel width
  localparam int DEPTH = (`KSIZE - 1) * `SCREEN_W + `KSIZE;

  // element 0 holds the newest pixel
  cnn_pkg::pixel_t sr [DEPTH];

  // advances only on a pixel strobe, idle cycles hold
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        sr[i] <= '0;
      end
    end else if (pix_valid) begin
      sr[0] <= pixel;
      for (int i = 1; i < DEPTH; i++) begin
        sr[i] <= sr[i-1];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // window taps
  //////////////////////////////////////////////////////////////////////

  // row r of the window sits (KSIZE-1-r) screen rows back
  // column c sits (KSIZE-1-c) pixels back in that row
  // raster order makes these taps correct wherever window_ctrl
  // raises win_valid
  always_comb begin
    for (int r = 0; r < `KSIZE; r++) begin
      for (int c = 0; c < `KSIZE; c++) begin
        window[r*`KSIZE + c] = sr[(`KSIZE-1-r)*`SCREEN_W + (`KSIZE-1-c)];
      end
    end
  end

  // window changes in the cycle after the strobe edge
  // so it lines up with win_valid from window_ctrl

endmodule

`default_nettype wire

/* mult_adder.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cnn_settings.svh"

// nine-tap multiply-adder tree with rectify and saturate
module mult_adder #(
  parameter logic [`WEIGHT_BITS*`KSIZE*`KSIZE-1:0] WEIGHTS = `KERNEL_0_WEIGHTS
) (
  input  logic              clock,
  input  logic              rst_n,
  input  cnn_pkg::window_t  window,
  output cnn_pkg::pixel_t   rect_out
);

  localparam int TAPS = `KSIZE * `KSIZE;
  localparam logic signed [`SUM_BITS-1:0] PIX_MAX = (1 << `PIX_BITS) - 1;

  logic signed [`SUM_BITS-1:0] weight_ext [TAPS];
  logic signed [`SUM_BITS-1:0] pixel_ext  [TAPS];
  logic signed [`SUM_BITS-1:0] prod       [TAPS];
  logic signed [`SUM_BITS-1:0] row_sum    [`KSIZE];
  logic signed [`SUM_BITS-1:0] total;

  // sign-extend weights, zero-extend pixels
  always_comb begin
    for (int i = 0; i < TAPS; i++) begin
      weight_ext[i] = signed'(WEIGHTS[`WEIGHT_BITS*i +: `WEIGHT_BITS]);
      pixel_ext[i]  = signed'({1'b0, window[i]});
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stage 1, products
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < TAPS; i++) begin
        prod[i] <= '0;
      end
    end else begin
      for (int i = 0; i < TAPS; i++) begin
        prod[i] <= weight_ext[i] * pixel_ext[i];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stage 2, row sums
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      for (int r = 0; r < `KSIZE; r++) begin
        row_sum[r] <= '0;
      end
    end else begin
      for (int r = 0; r < `KSIZE; r++) begin
        row_sum[r] <= prod[r*`KSIZE] + prod[r*`KSIZE+1] + prod[r*`KSIZE+2];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stage 3, rectify and saturate
  //////////////////////////////////////////////////////////////////////

  // worst case |sum| stays well inside SUM_BITS
  assign total = row_sum[0] + row_sum[1] + row_sum[2];

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      rect_out <= '0;
    end else if (total < 0) begin
      // relu, negatives to zero
      rect_out <= '0;
    end else if (total > PIX_MAX) begin
      rect_out <= '1;
    end else begin
      rect_out <= total[`PIX_BITS-1:0];
    end
  end

endmodule

`default_nettype wire

/* conv_tag_pipe.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cnn_settings.svh"

// carries window valid and position alongside the trees
module conv_tag_pipe (
  input  logic             clock,
  input  logic             rst_n,
  input  logic             win_valid,
  input  cnn_pkg::coord_t  win_pos,
  output logic             fm_we,
  output cnn_pkg::coord_t  fm_wr_pos
);

  // one stage per tree register stage
  logic            [`TREE_LATENCY-1:0] valid_sr;
  cnn_pkg::coord_t [`TREE_LATENCY-1:0] pos_sr;

  // valid bits, cleared by reset
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      valid_sr <= '0;
    end else begin
      valid_sr <= {valid_sr[`TREE_LATENCY-2:0], win_valid};
    end
  end

  // coordinates shift every cycle, up to three in flight
  always_ff @(posedge clock) begin
    pos_sr <= {pos_sr[`TREE_LATENCY-2:0], win_pos};
  end

  // aligned with rect_out of every tree
  assign fm_we     = valid_sr[`TREE_LATENCY-1];
  assign fm_wr_pos = pos_sr[`TREE_LATENCY-1];

endmodule

`default_nettype wire

/* fm_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cnn_settings.svh"

// feature map RAM with frame counter and host read port
module fm_buffer (
  input  logic                 clock,
  input  logic                 rst_n,
  input  logic                 fm_we,
  input  cnn_pkg::fm_wr_t      fm_wr,
  input  logic                 rd_strobe,
  input  cnn_pkg::fm_rd_req_t  rd_req,
  output logic                 rd_valid,
  output cnn_pkg::pixel_t      rd_data,
  output logic                 frame_done
);

  localparam int ADDR_BITS = $clog2(`FM_DEPTH);
  localparam logic [ADDR_BITS-1:0] LAST_WRITE = `FM_DEPTH - 1;

  cnn_pkg::fm_word_t mem [`FM_DEPTH];

  logic [ADDR_BITS-1:0] wr_addr;
  logic [ADDR_BITS-1:0] rd_addr;
  logic [ADDR_BITS-1:0] wr_count;

  // row-major, y * FM_W + x
  assign wr_addr = ADDR_BITS'(fm_wr.pos.y * `FM_W + fm_wr.pos.x);
  assign rd_addr = ADDR_BITS'(rd_req.pos.y * `FM_W + rd_req.pos.x);

  //////////////////////////////////////////////////////////////////////
  // write side
  //////////////////////////////////////////////////////////////////////

  // all kernel lanes land in one word
  always_ff @(posedge clock) begin
    if (fm_we) begin
      mem[wr_addr] <= fm_wr.value;
    end
  end

  // counts writes, pulses once per frame
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      wr_count   <= '0;
      frame_done <= 1'b0;
    end else begin
      frame_done <= fm_we && (wr_count == LAST_WRITE);
      if (fm_we) begin
        if (wr_count == LAST_WRITE) begin
          wr_count <= '0;
        end else begin
          wr_count <= wr_count + 1'b1;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read side
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_strobe;
    end
  end

  // old word on a same-cycle write to the same address
  always_ff @(posedge clock) begin
    if (rd_strobe) begin
      rd_data <= mem[rd_addr][rd_req.kernel];
    end
  end

endmodule

`default_nettype wire

/* cnn_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cnn_settings.svh"

// convolution front end for a raster pixel stream
module cnn_top (
  input  logic                 clock,
  input  logic                 rst_n,
  input  logic                 pix_valid,
  input  cnn_pkg::pix_in_t     pix_in,
  input  logic                 rd_strobe,
  input  cnn_pkg::fm_rd_req_t  rd_req,
  output logic                 rd_valid,
  output cnn_pkg::pixel_t      rd_data,
  output logic                 frame_done
);

  //////////////////////////////////////////////////////////////////////
  // wires
  //////////////////////////////////////////////////////////////////////

  // window stage
  logic              win_valid;
  cnn_pkg::coord_t   win_pos;
  cnn_pkg::window_t  window;

  // tree outputs, one lane per kernel
  cnn_pkg::fm_word_t lane_values;

  // tag pipe to RAM
  logic              fm_we;
  cnn_pkg::coord_t   fm_wr_pos;
  cnn_pkg::fm_wr_t   fm_wr;

  //////////////////////////////////////////////////////////////////////
  // window forming
  //////////////////////////////////////////////////////////////////////

  window_ctrl i_window_ctrl (
    .clock     (clock),
    .rst_n     (rst_n),
    .pix_valid (pix_valid),
    .pix_in    (pix_in),
    .win_valid (win_valid),
    .win_pos   (win_pos)
  );

  window_buffer i_window_buffer (
    .clock     (clock),
    .rst_n     (rst_n),
    .pix_valid (pix_valid),
    .pixel     (pix_in.data),
    .window    (window)
  );

  // one tree per kernel, same window
  for (genvar k = 0; k < `NUM_KERNELS; k++) begin : gen_kernel
    mult_adder #(
      .WEIGHTS ((k == 0) ? `KERNEL_0_WEIGHTS : `KERNEL_1_WEIGHTS)
    ) i_mult_adder (
      .clock    (clock),
      .rst_n    (rst_n),
      .window   (window),
      .rect_out (lane_values[k])
    );
  end

  // position follows the trees
  conv_tag_pipe i_conv_tag_pipe (
    .clock     (clock),
    .rst_n     (rst_n),
    .win_valid (win_valid),
    .win_pos   (win_pos),
    .fm_we     (fm_we),
    .fm_wr_pos (fm_wr_pos)
  );

  assign fm_wr.pos   = fm_wr_pos;
  assign fm_wr.value = lane_values;

  fm_buffer i_fm_buffer (
    .clock      (clock),
    .rst_n      (rst_n),
    .fm_we      (fm_we),
    .fm_wr      (fm_wr),
    .rd_strobe  (rd_strobe),
    .rd_req     (rd_req),
    .rd_valid   (rd_valid),
    .rd_data    (rd_data),
    .frame_done (frame_done)
  );

endmodule

`default_nettype wire

/* cnn_assertions.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cnn_settings.svh"

// protocol checks on the top level, bound into cnn_top
module cnn_assertions (
  input  wire logic              clock,
  input  wire logic              rst_n,
  input  wire logic              pix_valid,
  input  wire cnn_pkg::pix_in_t  pix_in,
  input  wire logic              rd_strobe,
  input  wire logic              rd_valid,
  input  wire logic              frame_done
);

  // failures seen so far, read by the testbench at the end
  int fail_count = 0;

  logic last_pixel;
  logic frame_seen;

  // bottom-right pixel of the screen
  assign last_pixel = pix_valid
                   && (pix_in.pos.x == `COORD_BITS'(`SCREEN_W - 1))
                   && (pix_in.pos.y == `COORD_BITS'(`SCREEN_H - 1));

  // set once the first frame has been fully strobed in
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      frame_seen <= 1'b0;
    end else if (last_pixel) begin
      frame_seen <= 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // reset and frame end
  //////////////////////////////////////////////////////////////////////

  // outputs quiet in reset and before the first frame
  assert property (@(posedge clock) !rst_n || !frame_seen |-> !rd_valid && !frame_done)
    else begin
      $error("rd_valid or frame_done high before the first frame");
      fail_count++;
    end

  // frame_done exactly five cycles after the last pixel
  assert property (@(posedge clock) disable iff (!rst_n)
                   $past(last_pixel, 5) |-> frame_done)
    else begin
      $error("frame_done missing five cycles after the last pixel");
      fail_count++;
    end

  assert property (@(posedge clock) disable iff (!rst_n)
                   frame_done |-> $past(last_pixel, 5))
    else begin
      $error("frame_done without a matching last pixel");
      fail_count++;
    end

  // single-cycle pulse
  assert property (@(posedge clock) disable iff (!rst_n)
                   frame_done |-> !$past(frame_done))
    else begin
      $error("frame_done held for more than one cycle");
      fail_count++;
    end

  //////////////////////////////////////////////////////////////////////
  // read port
  //////////////////////////////////////////////////////////////////////

  assert property (@(posedge clock) disable iff (!rst_n)
                   $past(rd_strobe) |-> rd_valid)
    else begin
      $error("rd_valid did not follow rd_strobe by one cycle");
      fail_count++;
    end

  assert property (@(posedge clock) disable iff (!rst_n)
                   rd_valid |-> $past(rd_strobe))
    else begin
      $error("rd_valid without a read strobe");
      fail_count++;
    end

endmodule

bind cnn_top cnn_assertions i_cnn_assertions (
  .clock      (clock),
  .rst_n      (rst_n),
  .pix_valid  (pix_valid),
  .pix_in     (pix_in),
  .rd_strobe  (rd_strobe),
  .rd_valid   (rd_valid),
  .frame_done (frame_done)
);

`default_nettype wire

/* tb_cnn_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cnn_settings.svh"

module tb_cnn_top;

  logic                 clock;
  logic                 rst_n;
  logic                 pix_valid;
  cnn_pkg::pix_in_t     pix_in;
  logic                 rd_strobe;
  cnn_pkg::fm_rd_req_t  rd_req;
  logic                 rd_valid;
  cnn_pkg::pixel_t      rd_data;
  logic                 frame_done;

  // frame being driven, and a copy for the replay
  logic [`PIX_BITS-1:0] frame_pix [`SCREEN_W*`SCREEN_H];
  logic [`PIX_BITS-1:0] saved_pix [`SCREEN_W*`SCREEN_H];

  int seed;
  int checks;
  int errors;
  int test_num;
  int checks_at_start;
  int errors_at_start;

  cnn_top i_dut (
    .clock      (clock),
    .rst_n      (rst_n),
    .pix_valid  (pix_valid),
    .pix_in     (pix_in),
    .rd_strobe  (rd_strobe),
    .rd_req     (rd_req),
    .rd_valid   (rd_valid),
    .rd_data    (rd_data),
    .frame_done (frame_done)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // signed weights times unsigned pixels over the 3x3 area, then clamp
  function automatic int ref_value(input int k, input int wx, input int wy);
    logic [`WEIGHT_BITS*`KSIZE*`KSIZE-1:0] weights;
    logic signed [`WEIGHT_BITS-1:0] w;
    int acc;
    weights = (k == 0) ? `KERNEL_0_WEIGHTS : `KERNEL_1_WEIGHTS;
    acc = 0;
    for (int dy = 0; dy < `KSIZE; dy++) begin
      for (int dx = 0; dx < `KSIZE; dx++) begin
        w = weights[`WEIGHT_BITS*(dy*`KSIZE + dx) +: `WEIGHT_BITS];
        acc += int'(w) * int'(frame_pix[(wy + dy)*`SCREEN_W + wx + dx]);
      end
    end
    if (acc < 0) begin
      return 0;
    end else if (acc > 255) begin
      return 255;
    end
    return acc;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string reason);
    $display("%0t ns: %s", $time, reason);
    $display("TEST RESULT: FAIL");
    $finish;
  endtask

  task automatic start_test();
    test_num++;
    checks_at_start = checks;
    errors_at_start = errors;
  endtask

  task automatic end_test(input string name);
    $display("test %0d %s: %0d checks, %0d errors", test_num, name,
             checks - checks_at_start, errors - errors_at_start);
  endtask

  task automatic check_data(input int k, input int x, input int y, input int expected);
    checks++;
    assert (rd_data == `PIX_BITS'(expected)) else begin
      $display("Fail at %0t ns: rd_data = %0d, expected %0d (kernel %0d, x %0d, y %0d)",
               $time, rd_data, expected, k, x, y);
      errors++;
    end
  endtask

  // raster order, optional random idle cycles before each strobe
  task automatic drive_frame(input int max_gap);
    int gap;
    for (int y = 0; y < `SCREEN_H; y++) begin
      for (int x = 0; x < `SCREEN_W; x++) begin
        gap = (max_gap > 0) ? ({$random(seed)} % (max_gap + 1)) : 0;
        repeat (gap) begin
          @(negedge clock);
          pix_valid = 1'b0;
        end
        @(negedge clock);
        pix_valid     = 1'b1;
        pix_in.pos.x  = `COORD_BITS'(x);
        pix_in.pos.y  = `COORD_BITS'(y);
        pix_in.data   = frame_pix[y*`SCREEN_W + x];
      end
    end
    @(negedge clock);
    pix_valid = 1'b0;
  endtask

  task automatic wait_frame_done(input int limit);
    int n;
    n = 0;
    while (!frame_done && n < limit) begin
      @(negedge clock);
      n++;
    end
    if (!frame_done) begin
      abort_run("timeout, frame_done never came");
    end
  endtask

  task automatic read_one(input int k, input int x, input int y, input int expected);
    int n;
    @(negedge clock);
    rd_strobe     = 1'b1;
    rd_req.kernel = k[0];
    rd_req.pos.x  = `COORD_BITS'(x);
    rd_req.pos.y  = `COORD_BITS'(y);
    @(negedge clock);
    rd_strobe = 1'b0;
    n = 0;
    while (!rd_valid && n < 8) begin
      @(negedge clock);
      n++;
    end
    if (!rd_valid) begin
      abort_run("timeout, rd_valid never answered the read");
    end else begin
      check_data(k, x, y, expected);
    end
  endtask

  // all positions of both kernels
  task automatic readback_frame(input bit saturated);
    int expected;
    for (int y = 0; y < `FM_H; y++) begin
      for (int x = 0; x < `FM_W; x++) begin
        for (int k = 0; k < `NUM_KERNELS; k++) begin
          if (saturated) begin
            expected = (k == 0) ? 255 : 0;
          end else begin
            expected = ref_value(k, x, y);
          end
          read_one(k, x, y, expected);
        end
      end
    end
  endtask

  // back-to-back strobes along one row, one result per cycle
  task automatic read_burst(input int k, input int y);
    for (int i = 0; i <= `FM_W; i++) begin
      @(negedge clock);
      if (i > 0) begin
        checks++;
        assert (rd_valid) else begin
          $display("Fail at %0t ns: rd_valid = %0b, expected 1", $time, rd_valid);
          errors++;
        end
        check_data(k, i - 1, y, ref_value(k, i - 1, y));
      end
      if (i < `FM_W) begin
        rd_strobe     = 1'b1;
        rd_req.kernel = k[0];
        rd_req.pos.x  = `COORD_BITS'(i);
        rd_req.pos.y  = `COORD_BITS'(y);
      end else begin
        rd_strobe = 1'b0;
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    rst_n     = 1'b0;
    pix_valid = 1'b0;
    pix_in    = '0;
    rd_strobe = 1'b0;
    rd_req    = '0;
    seed      = 32'he2fc70d5;
    checks    = 0;
    errors    = 0;
    test_num  = 0;
    repeat (2) @(posedge clock);
    @(negedge clock);
    rst_n = 1'b1;

    // outputs stay low out of reset
    start_test();
    repeat (4) @(negedge clock);
    checks++;
    assert (!rd_valid && !frame_done) else begin
      $display("Fail at %0t ns: rd_valid = %0b, frame_done = %0b, expected 0 and 0",
               $time, rd_valid, frame_done);
      errors++;
    end
    end_test("reset");

    // random frame, back to back
    for (int i = 0; i < `SCREEN_W*`SCREEN_H; i++) begin
      frame_pix[i] = `PIX_BITS'($random(seed));
      saved_pix[i] = frame_pix[i];
    end
    start_test();
    drive_frame(0);
    wait_frame_done(20);
    end_test("frame done");

    start_test();
    readback_frame(1'b0);
    end_test("readback");

    // all white, kernel 0 saturates and kernel 1 clamps
    for (int i = 0; i < `SCREEN_W*`SCREEN_H; i++) begin
      frame_pix[i] = '1;
    end
    start_test();
    drive_frame(0);
    wait_frame_done(20);
    readback_frame(1'b1);
    end_test("saturation");

    // same random frame with idle cycles
    for (int i = 0; i < `SCREEN_W*`SCREEN_H; i++) begin
      frame_pix[i] = saved_pix[i];
    end
    start_test();
    drive_frame(3);
    wait_frame_done(20);
    readback_frame(1'b0);
    end_test("idle gaps");

    start_test();
    read_burst(0, 1);
    read_burst(1, 4);
    end_test("read latency");

    // let the last reads pass the concurrent checks
    repeat (4) @(negedge clock);
    errors += i_dut.i_cnn_assertions.fail_count;
    $display("tests %0d, checks %0d, errors %0d (assertion failures %0d)",
             test_num, checks, errors, i_dut.i_cnn_assertions.fail_count);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+.
cnn_pkg.sv
window_ctrl.sv
window_buffer.sv
mult_adder.sv
conv_tag_pipe.sv
fm_buffer.sv
cnn_top.sv
cnn_assertions.sv
tb_cnn_top.sv

/* Makefile */
SIM  := obj_dir/Vtb_cnn_top
SRCS := $(wildcard *.sv *.svh)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): list.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
		--top-module tb_cnn_top -f list.f

# the log decides pass or fail
run: $(SIM)
	./$(SIM) +verilator+error+limit+1000 > sim.log 2>&1; cat sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then exit 1; fi
	@grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
